//--- verilog.f
+incdir+source
source/mesh_pkg.sv
source/mesh_two_fifo.sv
source/mesh_xy_route.sv
source/mesh_rr_arbiter.sv
source/mesh_crossbar_router.sv
source/mesh_router_buffered.sv
testbench/mesh_router_props.sv
testbench/tb_mesh_router.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module tb_mesh_router -o sim_mesh

out=$(./obj_dir/sim_mesh)
echo "$out"

if echo "$out" | grep -q "STATUS: PASS"
then
   exit 0
else
   exit 1
fi

//--- testbench/tb_mesh_router.sv
`timescale 1ns/10ps
`include "mesh_config.svh"

module tb_mesh_router;

   import mesh_pkg::*;

   localparam logic [4:0] stub_c = 5'b01000;
   localparam int my_x_c = 3;
   localparam int my_y_c = 3;
   localparam int max_cycles_c = 3000;
   localparam int seq_w_c = `MESH_DATA_W - 3;

   logic clk;
   logic rst_n;
   logic [4:0] valid_i;
   logic [4:0] ready_o;
   logic [4:0] valid_o;
   logic [4:0] ready_i;
   flit_t [4:0] data_i;
   flit_t [4:0] data_o;

   flit_t exp_q [5][$];
   int out_count [5];
   int errors;
   int tests_passed;
   int tests_failed;
   int cycles;
   int last_src_p;
   bit fair_watch;
   bit sending;

   mesh_router_buffered #(.stub_p(stub_c)) i_dut
   (
      .clk_i   (clk),
      .rst_n_i (rst_n),
      .valid_i (valid_i),
      .data_i  (data_i),
      .ready_o (ready_o),
      .valid_o (valid_o),
      .data_o  (data_o),
      .ready_i (ready_i),
      .my_x_i  (3'(my_x_c)),
      .my_y_i  (3'(my_y_c))
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // XY reference, x first, y grows toward south
   function automatic int route_port(flit_t f);
      if (int'(f.dest_x) > my_x_c) return int'(dir_east);
      if (int'(f.dest_x) < my_x_c) return int'(dir_w);
      if (int'(f.dest_y) > my_y_c) return int'(dir_s);
      if (int'(f.dest_y) < my_y_c) return int'(dir_n);
      return int'(dir_p);
   endfunction

   // source port sits in the top payload bits
   function automatic flit_t make_flit(int src, int x, int y, int seq);
      flit_t f;
      f.dest_x  = 3'(x);
      f.dest_y  = 3'(y);
      f.payload = {3'(src), seq_w_c'(seq)};
      return f;
   endfunction

   function automatic int source_of(flit_t f);
      return int'(f.payload[`MESH_DATA_W-1 -: 3]);
   endfunction

   function automatic void check_value(bit cond, string msg);
      assert (cond) else
      begin
         $display("[FAIL] %0t ns: %s", $time, msg);
         errors++;
      end
   endfunction

   // flits accepted but not yet delivered
   function automatic int outstanding();
      int n;
      n = 0;
      for (int o = 0; o < 5; o++) n += exp_q[o].size();
      return n;
   endfunction

   // oldest expected flit from the same source must match
   function automatic void match_output(int o, flit_t f);
      int idx;
      idx = -1;
      for (int j = 0; j < exp_q[o].size(); j++)
      begin
         if (idx < 0 && source_of(exp_q[o][j]) == source_of(f)) idx = j;
      end
      if (idx < 0)
      begin
         check_value(1'b0, $sformatf("unexpected flit %h on output %0d", f, o));
         return;
      end
      check_value(exp_q[o][idx] == f,
         $sformatf("output %0d got %h, expected %h", o, f, exp_q[o][idx]));
      exp_q[o].delete(idx);
      out_count[o]++;
      if (o == 0 && fair_watch)
      begin
         if (last_src_p >= 0) check_value(source_of(f) != last_src_p, "P output repeated a source");
         last_src_p = source_of(f);
      end
   endfunction

   // handshakes are sampled mid-cycle where every signal is settled
   task automatic run_monitor();
      forever
      begin
         @(negedge clk);
         if (rst_n)
         begin
            for (int i = 0; i < 5; i++)
            begin
               if (valid_i[i] && ready_o[i]) exp_q[route_port(data_i[i])].push_back(data_i[i]);
            end
            for (int o = 0; o < 5; o++)
            begin
               if (valid_o[o] && ready_i[o]) match_output(o, data_o[o]);
            end
         end
      end
   endtask

   task automatic watch_timeout();
      while (cycles < max_cycles_c)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("timeout: run exceeded %0d cycles", max_cycles_c);
      $display("STATUS: FAIL");
      $finish;
   endtask

   task automatic sync();
      @(posedge clk);
      #2;
   endtask

   // called 2 ns after an edge, returns 2 ns after the accepting edge
   task automatic send_flit(int p, flit_t f);
      bit done;
      done = 1'b0;
      valid_i[p] = 1'b1;
      data_i[p]  = f;
      while (!done)
      begin
         @(negedge clk);
         done = ready_o[p];
         sync();
      end
      valid_i[p] = 1'b0;
   endtask

   task automatic drain(int limit);
      int n;
      n = 0;
      while (n < limit && outstanding() != 0)
      begin
         sync();
         n++;
      end
      if (outstanding() != 0)
      begin
         $display("flits still outstanding after %0d cycles", limit);
         errors++;
      end
   endtask

   task automatic finish_test(string name, int err_before);
      if (errors == err_before)
      begin
         tests_passed++;
         $display("test %s: ok", name);
      end
      else
      begin
         tests_failed++;
         $display("test %s: %0d errors", name, errors - err_before);
      end
   endtask

   task automatic test_reset();
      int e0;
      e0 = errors;
      sync();
      check_value(valid_o == 5'b00000, "valid_o not low after reset");
      check_value(ready_o == ~stub_c, "ready_o wrong after reset");
      finish_test("reset", e0);
   endtask

   task automatic test_routing();
      int e0;
      int src [4];
      int dx [4];
      int dy [4];
      e0 = errors;
      src = '{0, 1, 2, 4};
      dx = '{5, 1, 3, 3};
      dy = '{3, 3, 6, 3};
      for (int s = 0; s < 4; s++)
      begin
         for (int d = 0; d < 4; d++)
         begin
            sync();
            send_flit(src[s], make_flit(src[s], dx[d], dy[d], s * 4 + d));
            drain(20);
         end
      end
      finish_test("routing", e0);
   endtask

   task automatic test_fairness();
      int e0;
      int p0;
      e0 = errors;
      p0 = out_count[0];
      fair_watch = 1'b1;
      last_src_p = -1;
      sync();
      fork
         for (int k = 0; k < 6; k++) send_flit(1, make_flit(1, 3, 3, k));
         for (int k = 0; k < 6; k++) send_flit(2, make_flit(2, 3, 3, k));
      join
      drain(40);
      check_value(out_count[0] - p0 == 12, "P output count wrong after contention");
      fair_watch = 1'b0;
      finish_test("fairness", e0);
   endtask

   task automatic test_backpressure();
      int e0;
      int east0;
      flit_t first;
      e0 = errors;
      east0 = out_count[2];
      first = make_flit(0, 3, 5, 0);
      sync();
      ready_i[4] = 1'b0;
      fork
         for (int k = 0; k < 4; k++) send_flit(0, make_flit(0, 3, 5, k));
         for (int k = 0; k < 3; k++) send_flit(1, make_flit(1, 6, 3, k));
         begin
            repeat (8) @(posedge clk);
            @(negedge clk);
            check_value(valid_o[4], "S valid_o low while stalled");
            check_value(data_o[4] == first, "S data_o not the first flit");
            check_value(!ready_o[0], "P ready_o high with full FIFO");
            check_value(out_count[2] - east0 == 3, "W to E traffic stalled");
            sync();
            ready_i[4] = 1'b1;
         end
      join
      drain(20);
      finish_test("backpressure", e0);
   endtask

   task automatic random_source(int p, int count);
      int x;
      int y;
      for (int k = 0; k < count; k++)
      begin
         x = int'($urandom % 8);
         y = int'($urandom % 8);
         // keep the route off the stubbed north port
         if (x == my_x_c && y < my_y_c) y = my_y_c + y;
         repeat ($urandom % 3) sync();
         send_flit(p, make_flit(p, x, y, k));
      end
   endtask

   task automatic test_random();
      int e0;
      e0 = errors;
      sync();
      sending = 1'b1;
      fork
         begin
            fork
               random_source(0, 75);
               random_source(1, 75);
               random_source(2, 75);
               random_source(4, 75);
            join
            sending = 1'b0;
         end
         while (sending)
         begin
            ready_i = 5'($urandom);
            sync();
         end
      join
      ready_i = 5'b11111;
      drain(200);
      for (int o = 0; o < 5; o++) check_value(exp_q[o].size() == 0, "reference queue not empty");
      finish_test("random", e0);
   endtask

   initial
   begin
      void'($urandom(32'h740d75ab));
      rst_n = 1'b0;
      valid_i = '0;
      data_i = '0;
      ready_i = 5'b11111;
      errors = 0;
      tests_passed = 0;
      tests_failed = 0;
      cycles = 0;
      fair_watch = 1'b0;
      sending = 1'b0;
      last_src_p = -1;
      for (int o = 0; o < 5; o++) out_count[o] = 0;
      fork
         run_monitor();
         watch_timeout();
      join_none
      repeat (10) @(posedge clk);
      #2;
      rst_n = 1'b1;
      test_reset();
      test_routing();
      test_fairness();
      test_backpressure();
      test_random();
      $display("tests passed %0d, failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

//--- testbench/mesh_router_props.sv
`timescale 1ns/10ps

module mesh_router_props
#(
   parameter logic [mesh_pkg::num_dirs_c-1:0] stub_p = '0
)
(
   input  logic                                       clk_i,
   input  logic                                       rst_n_i,
   input  logic            [mesh_pkg::num_dirs_c-1:0] valid_o,
   input  mesh_pkg::flit_t [mesh_pkg::num_dirs_c-1:0] data_o,
   input  logic            [mesh_pkg::num_dirs_c-1:0] ready_o,
   input  logic            [mesh_pkg::num_dirs_c-1:0] ready_i
);

   for (genvar i = 0; i < mesh_pkg::num_dirs_c; i++)
   begin : g_link
      // a blocked output keeps offering the same flit
      a_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
         valid_o[i] && !ready_i[i] |=> valid_o[i] && $stable(data_o[i]))
         else $error("valid_o[%0d] or data_o[%0d] changed while blocked", i, i);

      if (stub_p[i])
      begin : g_stub
         a_no_valid: assert property (@(posedge clk_i) !valid_o[i])
            else $error("stubbed port %0d raised valid_o", i);
         a_no_ready: assert property (@(posedge clk_i) !ready_o[i])
            else $error("stubbed port %0d raised ready_o", i);
      end
   end

endmodule

bind mesh_router_buffered mesh_router_props #(.stub_p(stub_p)) i_props
(
   .clk_i   (clk_i),
   .rst_n_i (rst_n_i),
   .valid_o (valid_o),
   .data_o  (data_o),
   .ready_o (ready_o),
   .ready_i (ready_i)
);

//--- source/mesh_router_buffered.sv
`timescale 1ns/10ps
`include "mesh_config.svh"

module mesh_router_buffered
#(
   parameter logic [mesh_pkg::num_dirs_c-1:0] stub_p = `MESH_STUB_DEFAULT
)
(
   input  logic                                       clk_i,
   input  logic                                       rst_n_i,

   // incoming links
   input  logic            [mesh_pkg::num_dirs_c-1:0] valid_i,
   input  mesh_pkg::flit_t [mesh_pkg::num_dirs_c-1:0] data_i,
   output logic            [mesh_pkg::num_dirs_c-1:0] ready_o,

   // outgoing links
   output logic            [mesh_pkg::num_dirs_c-1:0] valid_o,
   output mesh_pkg::flit_t [mesh_pkg::num_dirs_c-1:0] data_o,
   input  logic            [mesh_pkg::num_dirs_c-1:0] ready_i,

   // position of this node in the mesh
   input  logic [`MESH_X_CORD_W-1:0]                  my_x_i,
   input  logic [`MESH_Y_CORD_W-1:0]                  my_y_i
);

   import mesh_pkg::*;

   logic  [num_dirs_c-1:0] fifo_valid;
   flit_t [num_dirs_c-1:0] fifo_data;
   logic  [num_dirs_c-1:0] fifo_yumi;

   for (genvar i = 0; i < num_dirs_c; i++)
   begin : g_port
      if (stub_p[i])
      begin : g_stub
         // no buffer, never accepts from the neighbour
         assign fifo_valid[i] = 1'b0;
         assign fifo_data[i]  = '0;
         assign ready_o[i]    = 1'b0;
      end
      else
      begin : g_live
         mesh_two_fifo u_fifo
         (
            .clk_i   (clk_i),
            .rst_n_i (rst_n_i),
            .v_i     (valid_i[i]),
            .data_i  (data_i[i]),
            .ready_o (ready_o[i]),
            .v_o     (fifo_valid[i]),
            .data_o  (fifo_data[i]),
            .yumi_i  (fifo_yumi[i])
         );
      end
   end

   // output stubbing is masked inside the crossbar
   mesh_crossbar_router
   #(
      .stub_p (stub_p)
   )
   u_xbar
   (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .v_i     (fifo_valid),
      .data_i  (fifo_data),
      .yumi_o  (fifo_yumi),
      .v_o     (valid_o),
      .data_o  (data_o),
      .ready_i (ready_i),
      .my_x_i  (my_x_i),
      .my_y_i  (my_y_i)
   );

endmodule

//--- source/mesh_crossbar_router.sv
`timescale 1ns/10ps
`include "mesh_config.svh"

module mesh_crossbar_router
#(
   parameter logic [mesh_pkg::num_dirs_c-1:0] stub_p = '0
)
(
   input  logic                                    clk_i,
   input  logic                                    rst_n_i,

   // heads of the input FIFOs
   input  logic            [mesh_pkg::num_dirs_c-1:0] v_i,
   input  mesh_pkg::flit_t [mesh_pkg::num_dirs_c-1:0] data_i,
   output logic            [mesh_pkg::num_dirs_c-1:0] yumi_o,

   // output links
   output logic            [mesh_pkg::num_dirs_c-1:0] v_o,
   output mesh_pkg::flit_t [mesh_pkg::num_dirs_c-1:0] data_o,
   input  logic            [mesh_pkg::num_dirs_c-1:0] ready_i,

   input  logic [`MESH_X_CORD_W-1:0]               my_x_i,
   input  logic [`MESH_Y_CORD_W-1:0]               my_y_i
);

   import mesh_pkg::*;

   // requests indexed [input][output]
   logic [num_dirs_c-1:0][num_dirs_c-1:0] route_req;
   // requests and grants indexed [output][input]
   logic [num_dirs_c-1:0][num_dirs_c-1:0] out_req;
   logic [num_dirs_c-1:0][num_dirs_c-1:0] out_grant;
   logic [num_dirs_c-1:0]                 consume;

   for (genvar i = 0; i < num_dirs_c; i++)
   begin : g_route
      mesh_xy_route u_route
      (
         .v_i      (v_i[i]),
         .dest_x_i (data_i[i].dest_x),
         .dest_y_i (data_i[i].dest_y),
         .my_x_i   (my_x_i),
         .my_y_i   (my_y_i),
         .req_o    (route_req[i])
      );
   end

   for (genvar o = 0; o < num_dirs_c; o++)
   begin : g_out
      flit_t mux_data;

      // transpose, and drop anything aimed at a stubbed output
      for (genvar i = 0; i < num_dirs_c; i++)
      begin : g_req
         assign out_req[o][i] = route_req[i][o] & ~stub_p[o];
      end

      mesh_rr_arbiter
      #(
         .num_req_p (num_dirs_c)
      )
      u_arb
      (
         .clk_i     (clk_i),
         .rst_n_i   (rst_n_i),
         .req_i     (out_req[o]),
         .advance_i (consume[o]),
         .grant_o   (out_grant[o])
      );

      // grant is one-hot, so at most one head matches
      always_comb
      begin
         mux_data = '0;
         for (int k = 0; k < num_dirs_c; k++)
         begin
            if (out_grant[o][k])
            begin
               mux_data = data_i[k];
            end
         end
      end

      assign v_o[o]     = |out_grant[o];
      assign data_o[o]  = mux_data;
      // grant only counts when the link takes the flit
      assign consume[o] = v_o[o] & ready_i[o];
   end

   // each input wins at most one output, its route is one-hot
   always_comb
   begin
      yumi_o = '0;
      for (int o = 0; o < num_dirs_c; o++)
      begin
         for (int i = 0; i < num_dirs_c; i++)
         begin
            yumi_o[i] = yumi_o[i] | (out_grant[o][i] & consume[o]);
         end
      end
   end

endmodule

//--- source/mesh_rr_arbiter.sv
`timescale 1ns/10ps

module mesh_rr_arbiter
#(
   parameter int num_req_p = 5
)
(
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  logic [num_req_p-1:0] req_i,
   input  logic                 advance_i,
   output logic [num_req_p-1:0] grant_o
);

   localparam int ptr_w_lp = (num_req_p > 1) ? $clog2(num_req_p) : 1;

   logic [ptr_w_lp-1:0] ptr_q;
   logic [ptr_w_lp-1:0] grant_idx;
   logic                found;

   // search upward from the pointer, wrapping past the top
   always_comb
   begin
      int cand;
      grant_o   = '0;
      grant_idx = ptr_q;
      found     = 1'b0;
      for (int k = 0; k < num_req_p; k++)
      begin
         cand = (int'(ptr_q) + k) % num_req_p;
         if (!found && req_i[cand])
         begin
            found          = 1'b1;
            grant_o[cand]  = 1'b1;
            grant_idx      = ptr_w_lp'(cand);
         end
      end
   end

   // winner drops to lowest priority once its grant is used
   // a blocked winner keeps top priority so the offered flit stays put
   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         ptr_q <= '0;
      end
      else if (found)
      begin
         if (!advance_i)
         begin
            ptr_q <= grant_idx;
         end
         else if (grant_idx == ptr_w_lp'(num_req_p - 1))
         begin
            ptr_q <= '0;
         end
         else
         begin
            ptr_q <= grant_idx + 1'b1;
         end
      end
   end

endmodule

//--- source/mesh_xy_route.sv
`timescale 1ns/10ps
`include "mesh_config.svh"

module mesh_xy_route
(
   input  logic                            v_i,
   input  logic [`MESH_X_CORD_W-1:0]       dest_x_i,
   input  logic [`MESH_Y_CORD_W-1:0]       dest_y_i,
   input  logic [`MESH_X_CORD_W-1:0]       my_x_i,
   input  logic [`MESH_Y_CORD_W-1:0]       my_y_i,
   output logic [mesh_pkg::num_dirs_c-1:0] req_o
);

   import mesh_pkg::*;

   // dimension-ordered routing, x resolved before y
   always_comb
   begin
      req_o = '0;
      if (v_i)
      begin
         if (dest_x_i > my_x_i)
         begin
            req_o[dir_east] = 1'b1;
         end
         else if (dest_x_i < my_x_i)
         begin
            req_o[dir_w] = 1'b1;
         end
         // y grows toward south
         else if (dest_y_i > my_y_i)
         begin
            req_o[dir_s] = 1'b1;
         end
         else if (dest_y_i < my_y_i)
         begin
            req_o[dir_n] = 1'b1;
         end
         else
         begin
            // arrived, deliver locally
            req_o[dir_p] = 1'b1;
         end
      end
   end

endmodule

//--- source/mesh_two_fifo.sv
`timescale 1ns/10ps

module mesh_two_fifo
(
   input  logic            clk_i,
   input  logic            rst_n_i,

   input  logic            v_i,
   input  mesh_pkg::flit_t data_i,
   output logic            ready_o,

   output logic            v_o,
   output mesh_pkg::flit_t data_o,
   input  logic            yumi_i
);

   import mesh_pkg::*;

   flit_t mem_q [2];

   logic  wr_ptr_q;
   logic  rd_ptr_q;
   logic  full_q;
   logic  empty_q;
   logic  enq;
   logic  deq;

   // enqueue only into a free slot
   assign enq = v_i & ready_o;
   assign deq = yumi_i;

   always_ff @(posedge clk_i)
   begin
      if (!rst_n_i)
      begin
         wr_ptr_q <= 1'b0;
         rd_ptr_q <= 1'b0;
         full_q   <= 1'b0;
         empty_q  <= 1'b1;
      end
      else
      begin
         wr_ptr_q <= wr_ptr_q ^ enq;
         rd_ptr_q <= rd_ptr_q ^ deq;
         // occupancy only moves when exactly one side fires
         if (enq && !deq)
         begin
            empty_q <= 1'b0;
            full_q  <= ~empty_q;
         end
         else if (deq && !enq)
         begin
            full_q  <= 1'b0;
            empty_q <= ~full_q;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (enq)
      begin
         mem_q[wr_ptr_q] <= data_i;
      end
   end

   assign ready_o = ~full_q;
   assign v_o     = ~empty_q;
   assign data_o  = mem_q[rd_ptr_q];

endmodule

//--- source/mesh_pkg.sv
`include "mesh_config.svh"

package mesh_pkg;

   // ports per router
   localparam int num_dirs_c = 5;

   // port index, also the bit position in request and stub vectors
   typedef enum logic [2:0]
   {
      dir_p    = 3'd0,
      dir_w    = 3'd1,
      dir_east = 3'd2,
      dir_n    = 3'd3,
      dir_s    = 3'd4
   } dir_e;

   // destination in the upper bits, payload in the lower ones
   typedef struct packed
   {
      logic [`MESH_Y_CORD_W-1:0] dest_y;
      logic [`MESH_X_CORD_W-1:0] dest_x;
      logic [`MESH_DATA_W-1:0]   payload;
   } flit_t;

endpackage

//--- source/mesh_config.svh
`ifndef MESH_CONFIG_SVH
`define MESH_CONFIG_SVH

// payload bits carried by every flit
`define MESH_DATA_W 16

// mesh coordinate widths
`define MESH_X_CORD_W 3
`define MESH_Y_CORD_W 3

// stub mask, one bit per port
// bit 0 is P, then W, E, N, S up to bit 4
// a set bit removes that port from the node
`define MESH_STUB_DEFAULT 5'b00000

`endif
